/* hw/cia_reg_pkg.sv */
/*
 * Register map of the interface adapter.
 * Bus and timer widths, register addresses
 * and bit positions inside CRA and CRB.
 */

`default_nettype none

package cia_reg_pkg;

    localparam int DATA_W  = 8;
    localparam int ADDR_W  = 4;
    localparam int TIMER_W = 16;

    // Register addresses.
    localparam logic [ADDR_W-1:0] REG_PRA   = 4'h0;
    localparam logic [ADDR_W-1:0] REG_PRB   = 4'h1;
    localparam logic [ADDR_W-1:0] REG_DDRA  = 4'h2;
    localparam logic [ADDR_W-1:0] REG_DDRB  = 4'h3;
    localparam logic [ADDR_W-1:0] REG_TA_LO = 4'h4;
    localparam logic [ADDR_W-1:0] REG_TA_HI = 4'h5;
    localparam logic [ADDR_W-1:0] REG_TB_LO = 4'h6;
    localparam logic [ADDR_W-1:0] REG_TB_HI = 4'h7;
    localparam logic [ADDR_W-1:0] REG_ICR   = 4'hd;
    localparam logic [ADDR_W-1:0] REG_CRA   = 4'he;
    localparam logic [ADDR_W-1:0] REG_CRB   = 4'hf;

    // Control register bits.
    localparam int CR_START   = 0;
    localparam int CR_ONESHOT = 3;
    localparam int CR_LOAD    = 4;
    localparam int CR_CASCADE = 6;

endpackage

`default_nettype wire

/* hw/cia_irq_pkg.sv */
/*
 * Interrupt definitions.
 * Source bit positions and the ICR byte,
 * which is decoded one way on writes and another on reads.
 */

`default_nettype none

package cia_irq_pkg;

    localparam int ICR_W = 5;

    localparam int IRQ_TA      = 0;
    localparam int IRQ_TB      = 1;
    localparam int IRQ_FLAG    = 4;
    localparam int ICR_SET_BIT = 7;

    // Write view selects mask set or clear.
    typedef struct packed {
        logic             set_clear;
        logic [1:0]       spare;
        logic [ICR_W-1:0] mask_bits;
    } icr_write_t;

    // Read view shows the pending flags.
    typedef struct packed {
        logic             active;
        logic [1:0]       spare;
        logic [ICR_W-1:0] flags;
    } icr_read_t;

    typedef union packed {
        icr_write_t wr;
        icr_read_t  rd;
    } icr_word_u;

endpackage

`default_nettype wire

/* hw/register_bus.sv */
/*
 * Bus decoder.
 * One-hot write strobes, the ICR read strobe
 * and the read data multiplexer.
 */

`timescale 1ns/1ns
`default_nettype none

module register_bus import cia_reg_pkg::*, cia_irq_pkg::*; (
    input  wire logic              CNT,
    input  wire logic              RESET_n,
    input  wire logic              cs_n,
    input  wire logic              rw,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] pa_read,
    input  wire logic [DATA_W-1:0] pb_read,
    input  wire logic [DATA_W-1:0] ddra,
    input  wire logic [DATA_W-1:0] ddrb,
    input  wire logic [TIMER_W-1:0] ta_count,
    input  wire logic [TIMER_W-1:0] tb_count,
    input  wire logic [DATA_W-1:0] cra,
    input  wire logic [DATA_W-1:0] crb,
    input  wire icr_word_u         icr_status,
    output logic                   wr_pra,
    output logic                   wr_prb,
    output logic                   wr_ddra,
    output logic                   wr_ddrb,
    output logic                   wr_ta_lo,
    output logic                   wr_ta_hi,
    output logic                   wr_tb_lo,
    output logic                   wr_tb_hi,
    output logic                   wr_cra,
    output logic                   wr_crb,
    output logic                   wr_icr,
    output logic                   rd_icr,
    output logic [DATA_W-1:0]      rd_data
);

    logic wr_en;
    logic rd_en;

    assign wr_en = !cs_n && !rw;
    assign rd_en = !cs_n && rw;

    assign wr_pra   = wr_en && (addr == REG_PRA);
    assign wr_prb   = wr_en && (addr == REG_PRB);
    assign wr_ddra  = wr_en && (addr == REG_DDRA);
    assign wr_ddrb  = wr_en && (addr == REG_DDRB);
    assign wr_ta_lo = wr_en && (addr == REG_TA_LO);
    assign wr_ta_hi = wr_en && (addr == REG_TA_HI);
    assign wr_tb_lo = wr_en && (addr == REG_TB_LO);
    assign wr_tb_hi = wr_en && (addr == REG_TB_HI);
    assign wr_cra   = wr_en && (addr == REG_CRA);
    assign wr_crb   = wr_en && (addr == REG_CRB);
    assign wr_icr   = wr_en && (addr == REG_ICR);

    // Flags clear at the end of this read.
    assign rd_icr = rd_en && (addr == REG_ICR);

    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (addr)
                REG_PRA:   rd_data = pa_read;
                REG_PRB:   rd_data = pb_read;
                REG_DDRA:  rd_data = ddra;
                REG_DDRB:  rd_data = ddrb;
                REG_TA_LO: rd_data = ta_count[DATA_W-1:0];
                REG_TA_HI: rd_data = ta_count[TIMER_W-1:DATA_W];
                REG_TB_LO: rd_data = tb_count[DATA_W-1:0];
                REG_TB_HI: rd_data = tb_count[TIMER_W-1:DATA_W];
                REG_ICR:   rd_data = icr_status;
                REG_CRA:   rd_data = cra;
                REG_CRB:   rd_data = crb;
                default:   rd_data = '0;
            endcase
        end
    end

    a_one_strobe: assert property (@(posedge CNT) disable iff (!RESET_n)
        $onehot0({wr_pra, wr_prb, wr_ddra, wr_ddrb, wr_ta_lo, wr_ta_hi,
                  wr_tb_lo, wr_tb_hi, wr_cra, wr_crb, wr_icr}));

endmodule

`default_nettype wire

/* hw/io_ports.sv */
/*
 * Parallel ports A and B.
 * Data and direction registers, pin read merge
 * and falling edge detection on flag_n.
 */

`timescale 1ns/1ns
`default_nettype none

module io_ports import cia_reg_pkg::*; (
    input  wire logic              CNT,
    input  wire logic              RESET_n,
    input  wire logic              wr_pra,
    input  wire logic              wr_prb,
    input  wire logic              wr_ddra,
    input  wire logic              wr_ddrb,
    input  wire logic [DATA_W-1:0] wr_data,
    input  wire logic [DATA_W-1:0] pa_in,
    input  wire logic [DATA_W-1:0] pb_in,
    input  wire logic              flag_n,
    output logic [DATA_W-1:0]      pa_out,
    output logic [DATA_W-1:0]      pa_oe,
    output logic [DATA_W-1:0]      pb_out,
    output logic [DATA_W-1:0]      pb_oe,
    output logic [DATA_W-1:0]      pa_read,
    output logic [DATA_W-1:0]      pb_read,
    output logic [DATA_W-1:0]      ddra,
    output logic [DATA_W-1:0]      ddrb,
    output logic                   flag_fall
);

    logic [DATA_W-1:0] pra;
    logic [DATA_W-1:0] prb;
    logic              flag_q;
    logic              flag_qq;

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            pra  <= '0;
            prb  <= '0;
            ddra <= '0;
            ddrb <= '0;
        end else begin
            if (wr_pra)  pra  <= wr_data;
            if (wr_prb)  prb  <= wr_data;
            if (wr_ddra) ddra <= wr_data;
            if (wr_ddrb) ddrb <= wr_data;
        end
    end

    assign pa_out = pra;
    assign pa_oe  = ddra;
    assign pb_out = prb;
    assign pb_oe  = ddrb;

    // Output bits read back the register, inputs read the pin.
    assign pa_read = (pra & ddra) | (pa_in & ~ddra);
    assign pb_read = (prb & ddrb) | (pb_in & ~ddrb);

    // Idle high so that leaving reset makes no edge.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            flag_q  <= 1'b1;
            flag_qq <= 1'b1;
        end else begin
            flag_q  <= flag_n;
            flag_qq <= flag_q;
        end
    end

    assign flag_fall = flag_qq && !flag_q;

    a_flag_single: assert property (@(posedge CNT) disable iff (!RESET_n)
        flag_fall |=> !flag_fall);

endmodule

`default_nettype wire

/* hw/interval_timers.sv */
/*
 * Interval timers A and B.
 * Latches, down counters, CRA and CRB,
 * force load, one-shot start and stop, reload on underflow,
 * and timer B counting timer A underflows.
 */

`timescale 1ns/1ns
`default_nettype none

module interval_timers import cia_reg_pkg::*; (
    input  wire logic              CNT,
    input  wire logic              RESET_n,
    input  wire logic              wr_ta_lo,
    input  wire logic              wr_ta_hi,
    input  wire logic              wr_tb_lo,
    input  wire logic              wr_tb_hi,
    input  wire logic              wr_cra,
    input  wire logic              wr_crb,
    input  wire logic [DATA_W-1:0] wr_data,
    output logic [TIMER_W-1:0]     ta_count,
    output logic [TIMER_W-1:0]     tb_count,
    output logic [DATA_W-1:0]      cra,
    output logic [DATA_W-1:0]      crb,
    output logic                   ta_underflow,
    output logic                   tb_underflow
);

    logic [TIMER_W-1:0] ta_latch;
    logic [TIMER_W-1:0] tb_latch;
    logic               ta_run;
    logic               ta_oneshot;
    logic               tb_run;
    logic               tb_oneshot;
    logic               tb_cascade;
    logic               tb_tick;

    // Priority is force load, then high byte load, then counting.
    function automatic logic [TIMER_W-1:0] next_count(
        input logic [TIMER_W-1:0] count,
        input logic [TIMER_W-1:0] latch,
        input logic               force_load,
        input logic               hi_load,
        input logic               tick,
        input logic [DATA_W-1:0]  hi_byte
    );
        if (force_load)
            return latch;
        if (hi_load)
            return {hi_byte, latch[DATA_W-1:0]};
        if (tick)
            return (count == '0) ? latch : count - 1'b1;
        return count;
    endfunction

    // A CR write wins over the one-shot start and stop.
    function automatic logic next_run(
        input logic run,
        input logic oneshot,
        input logic wr_cr,
        input logic start,
        input logic wr_hi,
        input logic underflow
    );
        if (wr_cr)
            return start;
        if (wr_hi && oneshot)
            return 1'b1;
        if (underflow && oneshot)
            return 1'b0;
        return run;
    endfunction

    assign tb_tick      = tb_run && (!tb_cascade || ta_underflow);
    assign ta_underflow = ta_run && (ta_count == '0);
    assign tb_underflow = tb_tick && (tb_count == '0);

    // Latches come up all ones.
    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            ta_latch <= '1;
            tb_latch <= '1;
        end else begin
            if (wr_ta_lo) ta_latch[DATA_W-1:0]       <= wr_data;
            if (wr_ta_hi) ta_latch[TIMER_W-1:DATA_W] <= wr_data;
            if (wr_tb_lo) tb_latch[DATA_W-1:0]       <= wr_data;
            if (wr_tb_hi) tb_latch[TIMER_W-1:DATA_W] <= wr_data;
        end
    end

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            ta_count <= '0;
            tb_count <= '0;
        end else begin
            ta_count <= next_count(ta_count, ta_latch, wr_cra && wr_data[CR_LOAD],
                                   wr_ta_hi && (!ta_run || ta_oneshot), ta_run, wr_data);
            tb_count <= next_count(tb_count, tb_latch, wr_crb && wr_data[CR_LOAD],
                                   wr_tb_hi && (!tb_run || tb_oneshot), tb_tick, wr_data);
        end
    end

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            ta_run     <= 1'b0;
            tb_run     <= 1'b0;
            ta_oneshot <= 1'b0;
            tb_oneshot <= 1'b0;
            tb_cascade <= 1'b0;
        end else begin
            ta_run <= next_run(ta_run, ta_oneshot, wr_cra, wr_data[CR_START],
                               wr_ta_hi, ta_underflow);
            tb_run <= next_run(tb_run, tb_oneshot, wr_crb, wr_data[CR_START],
                               wr_tb_hi, tb_underflow);
            if (wr_cra)
                ta_oneshot <= wr_data[CR_ONESHOT];
            if (wr_crb) begin
                tb_oneshot <= wr_data[CR_ONESHOT];
                tb_cascade <= wr_data[CR_CASCADE];
            end
        end
    end

    // Load bit is a strobe and reads zero.
    always_comb begin
        cra = '0;
        cra[CR_START]   = ta_run;
        cra[CR_ONESHOT] = ta_oneshot;
        crb = '0;
        crb[CR_START]   = tb_run;
        crb[CR_ONESHOT] = tb_oneshot;
        crb[CR_CASCADE] = tb_cascade;
    end

    a_ta_running: assert property (@(posedge CNT) disable iff (!RESET_n)
        ta_underflow |-> ta_run);

    a_tb_running: assert property (@(posedge CNT) disable iff (!RESET_n)
        tb_underflow |-> tb_run);

    a_cascade: assert property (@(posedge CNT) disable iff (!RESET_n)
        (tb_underflow && tb_cascade) |-> ta_underflow);

endmodule

`default_nettype wire

/* hw/interrupt_control.sv */
/*
 * Interrupt control register.
 * Mask set and clear, source flags with clear on read,
 * status byte and irq_n.
 */

`timescale 1ns/1ns
`default_nettype none

module interrupt_control import cia_irq_pkg::*; (
    input  wire logic       CNT,
    input  wire logic       RESET_n,
    input  wire logic       wr_icr,
    input  wire logic       rd_icr,
    input  wire logic [7:0] wr_data,
    input  wire logic       ta_underflow,
    input  wire logic       tb_underflow,
    input  wire logic       flag_fall,
    output icr_word_u       icr_status,
    output logic            irq_n
);

    logic [ICR_W-1:0] mask;
    logic [ICR_W-1:0] flags;
    logic [ICR_W-1:0] pulses;
    icr_word_u        wr_word;

    assign wr_word = wr_data;

    // Bits 2 and 3 have no source.
    always_comb begin
        pulses = '0;
        pulses[IRQ_TA]   = ta_underflow;
        pulses[IRQ_TB]   = tb_underflow;
        pulses[IRQ_FLAG] = flag_fall;
    end

    always_ff @(posedge CNT or negedge RESET_n) begin
        if (!RESET_n) begin
            mask  <= '0;
            flags <= '0;
        end else begin
            if (wr_icr) begin
                if (wr_word.wr.set_clear)
                    mask <= mask | wr_word.wr.mask_bits;
                else
                    mask <= mask & ~wr_word.wr.mask_bits;
            end
            // A pulse in the read cycle survives the clear.
            flags <= rd_icr ? pulses : (flags | pulses);
        end
    end

    always_comb begin
        icr_status.rd.active = |(flags & mask);
        icr_status.rd.spare  = 2'b00;
        icr_status.rd.flags  = flags;
    end

    assign irq_n = !icr_status[ICR_SET_BIT];

    a_irq_cause: assert property (@(posedge CNT) disable iff (!RESET_n)
        !irq_n |-> |(flags & mask));

endmodule

`default_nettype wire

/* hw/cia_top.sv */
/*
 * Interface adapter top level.
 * Bus decoder, ports, timers and interrupt control.
 */

`timescale 1ns/1ns
`default_nettype none

module cia_top import cia_reg_pkg::*, cia_irq_pkg::*; (
    input  wire logic              CNT,
    input  wire logic              RESET_n,
    input  wire logic              cs_n,
    input  wire logic              rw,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] wr_data,
    input  wire logic [DATA_W-1:0] pa_in,
    input  wire logic [DATA_W-1:0] pb_in,
    input  wire logic              flag_n,
    output logic [DATA_W-1:0]      rd_data,
    output logic [DATA_W-1:0]      pa_out,
    output logic [DATA_W-1:0]      pa_oe,
    output logic [DATA_W-1:0]      pb_out,
    output logic [DATA_W-1:0]      pb_oe,
    output logic                   irq_n
);

    logic wr_pra;
    logic wr_prb;
    logic wr_ddra;
    logic wr_ddrb;
    logic wr_ta_lo;
    logic wr_ta_hi;
    logic wr_tb_lo;
    logic wr_tb_hi;
    logic wr_cra;
    logic wr_crb;
    logic wr_icr;
    logic rd_icr;

    logic [DATA_W-1:0]  pa_read;
    logic [DATA_W-1:0]  pb_read;
    logic [DATA_W-1:0]  ddra;
    logic [DATA_W-1:0]  ddrb;
    logic [TIMER_W-1:0] ta_count;
    logic [TIMER_W-1:0] tb_count;
    logic [DATA_W-1:0]  cra;
    logic [DATA_W-1:0]  crb;
    logic               ta_underflow;
    logic               tb_underflow;
    logic               flag_fall;
    icr_word_u          icr_status;

    register_bus u_register_bus (.*);

    io_ports u_io_ports (.*);

    interval_timers u_interval_timers (.*);

    interrupt_control u_interrupt_control (.*);

endmodule

`default_nettype wire

/* bench/cia_tb.sv */
/*
 * Testbench for the interface adapter top level.
 * Clock, reset, watchdog, one-cycle bus tasks
 * and directed tests of ports, timers and interrupts.
 */

`timescale 1ns/1ns
`default_nettype none

module cia_tb import cia_reg_pkg::*, cia_irq_pkg::*; ();

    logic              CNT;
    logic              RESET_n;
    logic              cs_n;
    logic              rw;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] pa_in;
    logic [DATA_W-1:0] pb_in;
    logic              flag_n;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] pa_out;
    logic [DATA_W-1:0] pa_oe;
    logic [DATA_W-1:0] pb_out;
    logic [DATA_W-1:0] pb_oe;
    logic              irq_n;

    cia_top DUT (.*);

    initial begin
        CNT = 1'b0;
        forever #10 CNT = ~CNT;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    // Far above the roughly 130 cycles that all tests take.
    initial begin
        repeat (5000) @(posedge CNT);
        $display("Watchdog expired before the tests finished");
        abort_run();
    end

    task automatic check_byte(input string test_name, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", test_name, expected, actual);
            abort_run();
        end
    endtask

    // Every task starts and ends 2 ns after a rising edge.
    task automatic idle_cycle();
        @(posedge CNT);
        #2;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        cs_n    = 1'b0;
        rw      = 1'b0;
        addr    = a;
        wr_data = d;
        idle_cycle();
        cs_n = 1'b1;
        rw   = 1'b1;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
        cs_n = 1'b0;
        rw   = 1'b1;
        addr = a;
        #16;
        d = rd_data;
        idle_cycle();
        cs_n = 1'b1;
    endtask

    task automatic pulse_flag();
        flag_n = 1'b0;
        idle_cycle();
        flag_n = 1'b1;
    endtask

    task automatic reset_state();
        logic [DATA_W-1:0] rd;
        check_byte("reset_irq_n", 8'h01, {7'b0, irq_n});
        check_byte("reset_pa_oe", 8'h00, pa_oe);
        check_byte("reset_pb_oe", 8'h00, pb_oe);
        check_byte("reset_pa_out", 8'h00, pa_out);
        check_byte("reset_pb_out", 8'h00, pb_out);
        bus_read(REG_DDRA, rd);
        check_byte("reset_ddra", 8'h00, rd);
        bus_read(REG_DDRB, rd);
        check_byte("reset_ddrb", 8'h00, rd);
        bus_read(REG_CRA, rd);
        check_byte("reset_cra", 8'h00, rd);
        bus_read(REG_CRB, rd);
        check_byte("reset_crb", 8'h00, rd);
        bus_read(REG_ICR, rd);
        check_byte("reset_icr", 8'h00, rd);
    endtask

    task automatic port_io(input logic sel_b);
        logic [DATA_W-1:0] dir;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] pins;
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] exp_rd;
        logic [ADDR_W-1:0] pr_addr;
        logic [ADDR_W-1:0] ddr_addr;
        pr_addr  = sel_b ? REG_PRB : REG_PRA;
        ddr_addr = sel_b ? REG_DDRB : REG_DDRA;
        repeat (4) begin
            dir  = 8'($urandom);
            data = 8'($urandom);
            pins = 8'($urandom);
            if (sel_b)
                pb_in = pins;
            else
                pa_in = pins;
            bus_write(ddr_addr, dir);
            bus_write(pr_addr, data);
            check_byte("ports_oe", dir, sel_b ? pb_oe : pa_oe);
            check_byte("ports_out", data, sel_b ? pb_out : pa_out);
            // Direction 1 reads the data register, 0 reads the pin.
            for (int i = 0; i < DATA_W; i++)
                exp_rd[i] = dir[i] ? data[i] : pins[i];
            bus_read(pr_addr, rd);
            check_byte("ports_read", exp_rd, rd);
        end
    endtask

    task automatic oneshot_timer();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] st;
        int                latch;
        int                polls;
        latch = 12;
        bus_read(REG_ICR, rd);
        bus_write(REG_TA_LO, 8'(latch));
        bus_write(REG_CRA, 8'h08);
        bus_write(REG_TA_HI, 8'h00);
        bus_read(REG_CRA, rd);
        check_byte("oneshot_started", 8'h01, rd & 8'h01);
        polls = 0;
        st    = 8'h00;
        while (!st[IRQ_TA] && polls < latch + 2) begin
            bus_read(REG_ICR, st);
            polls = polls + 1;
        end
        assert (st[IRQ_TA]) else begin
            $display("Timer A flag did not appear within %0d ICR polls", polls);
            abort_run();
        end
        bus_read(REG_CRA, rd);
        check_byte("oneshot_stopped", 8'h00, rd & 8'h01);
        bus_read(REG_TA_LO, rd);
        check_byte("oneshot_reload_lo", 8'(latch), rd);
        bus_read(REG_TA_HI, rd);
        check_byte("oneshot_reload_hi", 8'h00, rd);
    endtask

    task automatic cascade_timers();
        logic [DATA_W-1:0] st;
        int                ta_seen;
        int                tb_seen;
        // Stop both timers and clear one-shot before loading.
        bus_write(REG_CRA, 8'h00);
        bus_write(REG_CRB, 8'h00);
        bus_write(REG_TA_LO, 8'h03);
        bus_write(REG_TA_HI, 8'h00);
        bus_write(REG_TB_LO, 8'h02);
        bus_write(REG_TB_HI, 8'h00);
        bus_write(REG_CRB, 8'h41);
        bus_read(REG_ICR, st);
        bus_write(REG_CRA, 8'h11);
        ta_seen = 0;
        tb_seen = 0;
        for (int i = 0; i < 40; i++) begin
            bus_read(REG_ICR, st);
            if (st[IRQ_TA])
                ta_seen = ta_seen + 1;
            if (st[IRQ_TB]) begin
                assert (st[IRQ_TA] && ta_seen == 3) else begin
                    $display("FAIL cascade: expected 3, actual %0d", ta_seen);
                    abort_run();
                end
                tb_seen = tb_seen + 1;
                ta_seen = 0;
            end
        end
        assert (tb_seen >= 2) else begin
            $display("Timer B underflowed only %0d times in cascade mode", tb_seen);
            abort_run();
        end
        bus_write(REG_CRA, 8'h00);
        bus_write(REG_CRB, 8'h00);
    endtask

    task automatic mask_and_flag();
        logic [DATA_W-1:0] rd;
        int                waits;
        bus_write(REG_ICR, 8'h1f);
        bus_read(REG_ICR, rd);
        bus_write(REG_ICR, 8'h90);
        pulse_flag();
        waits = 0;
        while (irq_n && waits < 5) begin
            idle_cycle();
            waits = waits + 1;
        end
        check_byte("mask_irq_low", 8'h00, {7'b0, irq_n});
        bus_read(REG_ICR, rd);
        check_byte("mask_icr_active", 8'h90, rd);
        check_byte("mask_irq_released", 8'h01, {7'b0, irq_n});
        // Masked off, the flag still shows but raises no interrupt.
        bus_write(REG_ICR, 8'h10);
        pulse_flag();
        repeat (4) begin
            idle_cycle();
            check_byte("unmasked_irq_high", 8'h01, {7'b0, irq_n});
        end
        bus_read(REG_ICR, rd);
        check_byte("unmasked_icr", 8'h10, rd);
    endtask

    initial begin
        RESET_n  = 1'b0;
        cs_n     = 1'b1;
        rw       = 1'b1;
        addr     = '0;
        wr_data  = '0;
        pa_in    = '0;
        pb_in    = '0;
        flag_n   = 1'b1;
        void'($urandom(15));
        repeat (8) @(posedge CNT);
        #2;
        RESET_n = 1'b1;
        reset_state();
        port_io(1'b0);
        port_io(1'b1);
        oneshot_timer();
        cascade_timers();
        mask_and_flag();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cia_reg_pkg.sv
hw/cia_irq_pkg.sv
hw/register_bus.sv
hw/io_ports.sv
hw/interval_timers.sv
hw/interrupt_control.sv
hw/cia_top.sv
bench/cia_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status of the simulation is the result.

cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f sim.f --top-module cia_tb -o cia_sim &&
    ./obj_dir/cia_sim ||
    exit 1
